/* filelist.f */
rtl/coder_types_pkg.sv
rtl/carry_ctrl_pkg.sv
rtl/carry_word_decode.sv
rtl/carry_resolve_exec.sv
rtl/carry_group_result.sv
rtl/carry_prop_top.sv
verif/carry_prop_scoreboard.sv
verif/carry_prop_tb.sv

/* Makefile */
# Verilator flow for the carry resolver testbench

TOP := carry_prop_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* verif/carry_prop_tb.sv */
// Carry resolver testbench: directed and seeded random frames checked by the scoreboard
module carry_prop_tb;
    import coder_types_pkg::*;

    localparam int RUN_W        = 8;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_EXTEND   = 100;

    // Cycles per phase including the directed ones
    localparam int PHASE_1_CYCLES = 10;
    localparam int PHASE_2_CYCLES = 40;
    localparam int PHASE_3_CYCLES = 60;
    localparam int PHASE_4_CYCLES = 80;
    localparam int PHASE_5_CYCLES = 120;
    localparam int PHASE_6_CYCLES = 50;
    localparam int DRAIN_CYCLES   = 3;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + PHASE_1_CYCLES + PHASE_2_CYCLES
                                  + PHASE_3_CYCLES + PHASE_4_CYCLES + PHASE_5_CYCLES
                                  + PHASE_6_CYCLES + DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 100;

    logic             clk;
    logic             arst_n;
    logic             start;
    logic             flush;
    word_count_t      word_count;
    word_t            word_1;
    word_t            word_2;
    logic             group_0_valid;
    logic             group_1_valid;
    logic             group_2_valid;
    byte_t            group_0_lead;
    byte_t            group_1_lead;
    byte_t            group_2_lead;
    byte_t            group_0_fill;
    byte_t            group_1_fill;
    byte_t            group_2_fill;
    logic [RUN_W-1:0] group_0_run;
    logic [RUN_W-1:0] group_1_run;
    logic [RUN_W-1:0] group_2_run;
    logic             last;

    int check_count;
    int error_count;
    int seed;
    int ext_run;
    int mark_checks;
    int mark_errors;

    carry_prop_top #(.RUN_W(RUN_W)) carry_prop_top_inst (
        .clk(clk), .arst_n(arst_n), .start(start), .flush(flush),
        .word_count(word_count), .word_1(word_1), .word_2(word_2),
        .group_0_valid(group_0_valid), .group_1_valid(group_1_valid),
        .group_2_valid(group_2_valid), .group_0_lead(group_0_lead),
        .group_1_lead(group_1_lead), .group_2_lead(group_2_lead),
        .group_0_fill(group_0_fill), .group_1_fill(group_1_fill),
        .group_2_fill(group_2_fill), .group_0_run(group_0_run),
        .group_1_run(group_1_run), .group_2_run(group_2_run), .last(last)
    );

    carry_prop_scoreboard #(.RUN_W(RUN_W)) scoreboard_inst (
        .clk(clk), .arst_n(arst_n), .start(start), .flush(flush),
        .word_count(word_count), .word_1(word_1), .word_2(word_2),
        .group_0_valid(group_0_valid), .group_1_valid(group_1_valid),
        .group_2_valid(group_2_valid), .group_0_lead(group_0_lead),
        .group_1_lead(group_1_lead), .group_2_lead(group_2_lead),
        .group_0_fill(group_0_fill), .group_1_fill(group_1_fill),
        .group_2_fill(group_2_fill), .group_0_run(group_0_run),
        .group_1_run(group_1_run), .group_2_run(group_2_run), .last(last),
        .check_count(check_count), .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    task automatic drive_cycle(input logic do_start, input logic do_flush,
                               input word_count_t count, input word_t w1, input word_t w2);
        @(posedge clk);
        #1;
        start      = do_start;
        flush      = do_flush;
        word_count = count;
        word_1     = w1;
        word_2     = w2;
    endtask

    // Picks a word that is 0xFF without carry ff_pct percent of the time
    task automatic pick_word(input int ff_pct, input int carry_pct, output word_t word);
        int    roll;
        byte_t value;
        bit    carry;
        roll = $random(seed);
        if ((($unsigned(roll) % 100) < ff_pct) && (ext_run < MAX_EXTEND)) begin
            word = {1'b0, 8'hFF};
            ext_run++;
        end else begin
            roll  = $random(seed);
            value = roll[7:0];
            roll  = $random(seed);
            carry = ($unsigned(roll) % 100) < carry_pct;
            // A plain 0xFF would only extend the run
            if (value == 8'hFF && !carry) begin
                value = 8'hFE;
            end
            word    = {carry, value};
            ext_run = 0;
        end
    endtask

    task automatic random_cycle(input int ff_pct, input int carry_pct,
                                input logic do_start, input logic do_flush);
        int          roll;
        word_count_t count;
        word_t       w1;
        word_t       w2;
        roll  = $random(seed);
        count = roll[1:0];
        // Lanes beyond the count carry junk that must be ignored
        roll  = $random(seed);
        w1    = roll[WORD_W-1:0];
        roll  = $random(seed);
        w2    = roll[WORD_W-1:0];
        if (count != 2'd0) begin
            pick_word(ff_pct, carry_pct, w1);
        end
        if (count[1]) begin
            pick_word(ff_pct, carry_pct, w2);
        end
        drive_cycle(do_start, do_flush, count, w1, w2);
    endtask

    task automatic report_phase(input int num, input string name);
        $display("Phase %0d %s: %0d checks, %0d errors", num, name,
                 check_count - mark_checks, error_count - mark_errors);
        mark_checks = check_count;
        mark_errors = error_count;
    endtask

    // --------------------------------------------------
    // Phases
    // --------------------------------------------------

    initial begin
        logic pending_start;
        logic do_flush;
        int   roll;
        arst_n        = 1'b0;
        start         = 1'b0;
        flush         = 1'b0;
        word_count    = '0;
        word_1        = '0;
        word_2        = '0;
        seed          = 77;
        ext_run       = 0;
        mark_checks   = 0;
        mark_errors   = 0;
        pending_start = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Nothing may come out until a held byte is resolved
        repeat (5) drive_cycle(1'b0, 1'b0, 2'd0, '0, '0);
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h023, '0);
        repeat (4) drive_cycle(1'b0, 1'b0, 2'd0, '0, '0);
        report_phase(1, "idle after reset");

        for (int i = 0; i < PHASE_2_CYCLES; i++) random_cycle(0, 0, 1'b0, 1'b0);
        report_phase(2, "plain pass-through");

        for (int i = 0; i < PHASE_3_CYCLES; i++) random_cycle(0, 40, 1'b0, 1'b0);
        report_phase(3, "carry into held byte");

        // Two 0xFF in one cycle and one more in the next, then a carry resolves all three
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h012, '0);
        drive_cycle(1'b0, 1'b0, 2'd2, 9'h0FF, 9'h0FF);
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h0FF, '0);
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h105, '0);
        for (int i = 0; i < PHASE_4_CYCLES - 5; i++) random_cycle(70, 30, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h0AA, '0);
        report_phase(4, "0xFF runs");

        // A new frame starts right after each flush
        for (int i = 0; i < PHASE_5_CYCLES; i++) begin
            roll     = $random(seed);
            do_flush = ($unsigned(roll) % 20) == 0;
            random_cycle(25, 30, pending_start, do_flush);
            pending_start = do_flush;
        end
        report_phase(5, "flush and last");

        // The byte 0x40 and its run are dropped by start and never released
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h040, '0);
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h0FF, '0);
        drive_cycle(1'b1, 1'b0, 2'd0, '0, '0);
        drive_cycle(1'b0, 1'b0, 2'd1, 9'h041, '0);
        drive_cycle(1'b0, 1'b1, 2'd0, '0, '0);
        for (int i = 0; i < PHASE_6_CYCLES - 5; i++) begin
            roll = $random(seed);
            random_cycle(25, 30, ($unsigned(roll) % 10) == 0, 1'b0);
        end
        drive_cycle(1'b0, 1'b1, 2'd0, '0, '0);
        drive_cycle(1'b0, 1'b0, 2'd0, '0, '0);
        drive_cycle(1'b0, 1'b0, 2'd0, '0, '0);
        @(negedge clk);
        #1;
        report_phase(6, "start discards state");

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the stimulus did not finish", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verif/carry_prop_scoreboard.sv */
// Carry resolver scoreboard: models the sequential resolve rule and checks every group slot
module carry_prop_scoreboard #(
    parameter int RUN_W = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         start,
    input  logic                         flush,
    input  coder_types_pkg::word_count_t word_count,
    input  coder_types_pkg::word_t       word_1,
    input  coder_types_pkg::word_t       word_2,
    input  logic                         group_0_valid,
    input  logic                         group_1_valid,
    input  logic                         group_2_valid,
    input  coder_types_pkg::byte_t       group_0_lead,
    input  coder_types_pkg::byte_t       group_1_lead,
    input  coder_types_pkg::byte_t       group_2_lead,
    input  coder_types_pkg::byte_t       group_0_fill,
    input  coder_types_pkg::byte_t       group_1_fill,
    input  coder_types_pkg::byte_t       group_2_fill,
    input  logic [RUN_W-1:0]             group_0_run,
    input  logic [RUN_W-1:0]             group_1_run,
    input  logic [RUN_W-1:0]             group_2_run,
    input  logic                         last,
    output int                           check_count,
    output int                           error_count
);
    import coder_types_pkg::*;
    import carry_ctrl_pkg::*;

    logic [NUM_GROUPS-1:0]             act_valid;
    logic [NUM_GROUPS-1:0][BYTE_W-1:0] act_lead;
    logic [NUM_GROUPS-1:0][BYTE_W-1:0] act_fill;
    logic [NUM_GROUPS-1:0][RUN_W-1:0]  act_run;

    // Reference state holds one pending byte and the 0xFF bytes queued behind it
    bit    held_valid;
    byte_t held_byte;
    int    run_len;

    // Groups expected on the outputs one cycle after the inputs
    bit    exp_valid [NUM_GROUPS];
    int    exp_lead  [NUM_GROUPS];
    int    exp_fill  [NUM_GROUPS];
    int    exp_run   [NUM_GROUPS];
    bit    exp_last;
    int    exp_slot;

    assign act_valid = {group_2_valid, group_1_valid, group_0_valid};
    assign act_lead  = {group_2_lead, group_1_lead, group_0_lead};
    assign act_fill  = {group_2_fill, group_1_fill, group_0_fill};
    assign act_run   = {group_2_run, group_1_run, group_0_run};

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    task automatic release_group(input bit carry);
        exp_valid[exp_slot] = 1'b1;
        exp_lead[exp_slot]  = (int'(held_byte) + int'(carry)) % 256;
        exp_fill[exp_slot]  = carry ? 'h00 : 'hFF;
        exp_run[exp_slot]   = run_len;
        exp_slot++;
    endtask

    task automatic apply_word(input word_t word);
        bit carry;
        carry = word[WORD_W-1];
        if (held_valid && (word[BYTE_W-1:0] == 8'hFF) && !carry) begin
            run_len++;
        end else begin
            if (held_valid) begin
                release_group(carry);
            end
            held_byte  = word[BYTE_W-1:0];
            held_valid = 1'b1;
            run_len    = 0;
        end
    endtask

    task automatic predict_cycle();
        int words;
        for (int k = 0; k < NUM_GROUPS; k++) begin
            exp_valid[k] = 1'b0;
            exp_lead[k]  = 0;
            exp_fill[k]  = 0;
            exp_run[k]   = 0;
        end
        exp_slot = 0;
        exp_last = 1'b0;
        if (!arst_n) begin
            held_valid = 1'b0;
            run_len    = 0;
        end else begin
            // Count 3 behaves like 2
            words = (int'(word_count) > 2) ? 2 : int'(word_count);
            if (start) begin
                held_valid = 1'b0;
                run_len    = 0;
            end
            if (words >= 1) begin
                apply_word(word_1);
            end
            if (words >= 2) begin
                apply_word(word_2);
            end
            if (flush) begin
                if (held_valid) begin
                    release_group(1'b0);
                end
                held_valid = 1'b0;
                run_len    = 0;
                exp_last   = 1'b1;
            end
        end
    endtask

    // --------------------------------------------------
    // Comparison
    // --------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_outputs();
        for (int k = 0; k < NUM_GROUPS; k++) begin
            check_value($sformatf("group_%0d_valid", k), 32'(act_valid[k]), 32'(exp_valid[k]));
            if (exp_valid[k]) begin
                check_value($sformatf("group_%0d_lead", k), 32'(act_lead[k]), exp_lead[k]);
                check_value($sformatf("group_%0d_fill", k), 32'(act_fill[k]), exp_fill[k]);
                check_value($sformatf("group_%0d_run", k), 32'(act_run[k]), exp_run[k]);
            end
        end
        check_value("last", 32'(last), 32'(exp_last));
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
        held_valid  = 1'b0;
        held_byte   = '0;
        run_len     = 0;
        exp_last    = 1'b0;
        exp_slot    = 0;
        for (int k = 0; k < NUM_GROUPS; k++) begin
            exp_valid[k] = 1'b0;
            exp_lead[k]  = 0;
            exp_fill[k]  = 0;
            exp_run[k]   = 0;
        end
    end

    // Inputs change just after the rising edge and outputs change at it, so both are settled
    // at the falling edge. The groups from the previous inputs are compared before the next
    // prediction is made
    always @(negedge clk) begin
        compare_outputs();
        predict_cycle();
    end

endmodule

/* rtl/carry_prop_top.sv */
// Carry propagation top: resolves coder word carries into compressed byte groups
module carry_prop_top #(
    parameter int RUN_W = 8
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic                        flush,
    input  coder_types_pkg::word_count_t word_count,
    input  coder_types_pkg::word_t      word_1,
    input  coder_types_pkg::word_t      word_2,
    output logic                        group_0_valid,
    output logic                        group_1_valid,
    output logic                        group_2_valid,
    output coder_types_pkg::byte_t      group_0_lead,
    output coder_types_pkg::byte_t      group_1_lead,
    output coder_types_pkg::byte_t      group_2_lead,
    output coder_types_pkg::byte_t      group_0_fill,
    output coder_types_pkg::byte_t      group_1_fill,
    output coder_types_pkg::byte_t      group_2_fill,
    output logic [RUN_W-1:0]            group_0_run,
    output logic [RUN_W-1:0]            group_1_run,
    output logic [RUN_W-1:0]            group_2_run,
    output logic                        last
);
    import coder_types_pkg::*;
    import carry_ctrl_pkg::*;

    // Decode to execute
    word_kind_t kind_1;
    word_kind_t kind_2;
    byte_t      byte_1;
    byte_t      byte_2;
    logic       carry_1;
    logic       carry_2;

    // Execute to result
    logic             emit_0;
    logic             emit_1;
    logic             emit_2;
    byte_t            held_0;
    byte_t            held_1;
    byte_t            held_2;
    logic             grp_carry_0;
    logic             grp_carry_1;
    logic             grp_carry_2;
    logic [RUN_W-1:0] run_0;
    logic [RUN_W-1:0] run_1;
    logic [RUN_W-1:0] run_2;
    logic             flush_done;

    carry_word_decode carry_word_decode_inst (
        .word_count (word_count),
        .word_1     (word_1),
        .word_2     (word_2),
        .kind_1     (kind_1),
        .kind_2     (kind_2),
        .byte_1     (byte_1),
        .byte_2     (byte_2),
        .carry_1    (carry_1),
        .carry_2    (carry_2)
    );

    carry_resolve_exec #(
        .RUN_W (RUN_W)
    ) carry_resolve_exec_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .flush      (flush),
        .kind_1     (kind_1),
        .kind_2     (kind_2),
        .byte_1     (byte_1),
        .byte_2     (byte_2),
        .carry_1    (carry_1),
        .carry_2    (carry_2),
        .emit_0     (emit_0),
        .emit_1     (emit_1),
        .emit_2     (emit_2),
        .held_0     (held_0),
        .held_1     (held_1),
        .held_2     (held_2),
        .carry_0    (grp_carry_0),
        .carry_1_o  (grp_carry_1),
        .carry_2_o  (grp_carry_2),
        .run_0      (run_0),
        .run_1      (run_1),
        .run_2      (run_2),
        .flush_done (flush_done)
    );

    carry_group_result #(
        .RUN_W (RUN_W)
    ) carry_group_result_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .emit_0        (emit_0),
        .emit_1        (emit_1),
        .emit_2        (emit_2),
        .held_0        (held_0),
        .held_1        (held_1),
        .held_2        (held_2),
        .carry_0       (grp_carry_0),
        .carry_1       (grp_carry_1),
        .carry_2       (grp_carry_2),
        .run_0         (run_0),
        .run_1         (run_1),
        .run_2         (run_2),
        .flush_done    (flush_done),
        .group_0_valid (group_0_valid),
        .group_1_valid (group_1_valid),
        .group_2_valid (group_2_valid),
        .group_0_lead  (group_0_lead),
        .group_1_lead  (group_1_lead),
        .group_2_lead  (group_2_lead),
        .group_0_fill  (group_0_fill),
        .group_1_fill  (group_1_fill),
        .group_2_fill  (group_2_fill),
        .group_0_run   (group_0_run),
        .group_1_run   (group_1_run),
        .group_2_run   (group_2_run),
        .last          (last)
    );

endmodule

/* rtl/carry_group_result.sv */
// Carry group result: forms lead and fill bytes and registers the released groups
module carry_group_result #(
    parameter int RUN_W = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   emit_0,
    input  logic                   emit_1,
    input  logic                   emit_2,
    input  coder_types_pkg::byte_t held_0,
    input  coder_types_pkg::byte_t held_1,
    input  coder_types_pkg::byte_t held_2,
    input  logic                   carry_0,
    input  logic                   carry_1,
    input  logic                   carry_2,
    input  logic [RUN_W-1:0]       run_0,
    input  logic [RUN_W-1:0]       run_1,
    input  logic [RUN_W-1:0]       run_2,
    input  logic                   flush_done,
    output logic                   group_0_valid,
    output logic                   group_1_valid,
    output logic                   group_2_valid,
    output coder_types_pkg::byte_t group_0_lead,
    output coder_types_pkg::byte_t group_1_lead,
    output coder_types_pkg::byte_t group_2_lead,
    output coder_types_pkg::byte_t group_0_fill,
    output coder_types_pkg::byte_t group_1_fill,
    output coder_types_pkg::byte_t group_2_fill,
    output logic [RUN_W-1:0]       group_0_run,
    output logic [RUN_W-1:0]       group_1_run,
    output logic [RUN_W-1:0]       group_2_run,
    output logic                   last
);
    import coder_types_pkg::*;
    import carry_ctrl_pkg::*;

    logic             emit_in  [NUM_GROUPS];
    byte_t            held_in  [NUM_GROUPS];
    logic             carry_in [NUM_GROUPS];
    logic [RUN_W-1:0] run_in   [NUM_GROUPS];

    logic             valid_q  [NUM_GROUPS];
    byte_t            lead_q   [NUM_GROUPS];
    byte_t            fill_q   [NUM_GROUPS];
    logic [RUN_W-1:0] run_q    [NUM_GROUPS];
    logic             last_q;

    assign emit_in  = '{emit_0, emit_1, emit_2};
    assign held_in  = '{held_0, held_1, held_2};
    assign carry_in = '{carry_0, carry_1, carry_2};
    assign run_in   = '{run_0, run_1, run_2};

    // --------------------------------------------------
    // Control flags
    // --------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < NUM_GROUPS; k++) begin
                valid_q[k] <= 1'b0;
            end
            last_q <= 1'b0;
        end else begin
            for (int k = 0; k < NUM_GROUPS; k++) begin
                valid_q[k] <= emit_in[k];
            end
            last_q <= flush_done;
        end
    end

    // --------------------------------------------------
    // Group payload
    // --------------------------------------------------

    // Lead wraps modulo 256; a carry turns the whole 0xFF run into 0x00
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_GROUPS; k++) begin
            lead_q[k] <= held_in[k] + {{(BYTE_W-1){1'b0}}, carry_in[k]};
            fill_q[k] <= carry_in[k] ? '0 : FF_BYTE;
            run_q[k]  <= run_in[k];
        end
    end

    assign group_0_valid = valid_q[0];
    assign group_1_valid = valid_q[1];
    assign group_2_valid = valid_q[2];
    assign group_0_lead  = lead_q[0];
    assign group_1_lead  = lead_q[1];
    assign group_2_lead  = lead_q[2];
    assign group_0_fill  = fill_q[0];
    assign group_1_fill  = fill_q[1];
    assign group_2_fill  = fill_q[2];
    assign group_0_run   = run_q[0];
    assign group_1_run   = run_q[1];
    assign group_2_run   = run_q[2];
    assign last          = last_q;

endmodule

/* rtl/carry_resolve_exec.sv */
// Carry resolve execute: tracks the held byte and its 0xFF run and emits resolved groups
module carry_resolve_exec #(
    parameter int RUN_W = 8
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic                       flush,
    input  carry_ctrl_pkg::word_kind_t kind_1,
    input  carry_ctrl_pkg::word_kind_t kind_2,
    input  coder_types_pkg::byte_t     byte_1,
    input  coder_types_pkg::byte_t     byte_2,
    input  logic                       carry_1,
    input  logic                       carry_2,
    output logic                       emit_0,
    output logic                       emit_1,
    output logic                       emit_2,
    output coder_types_pkg::byte_t     held_0,
    output coder_types_pkg::byte_t     held_1,
    output coder_types_pkg::byte_t     held_2,
    output logic                       carry_0,
    output logic                       carry_1_o,
    output logic                       carry_2_o,
    output logic [RUN_W-1:0]           run_0,
    output logic [RUN_W-1:0]           run_1,
    output logic [RUN_W-1:0]           run_2,
    output logic                       flush_done
);
    import coder_types_pkg::*;
    import carry_ctrl_pkg::*;

    localparam int NUM_WORDS = 2;
    localparam int SLOT_W    = $clog2(NUM_GROUPS + 1);

    typedef logic [RUN_W-1:0] run_t;

    // Registered state
    hold_state_t hold_q;
    hold_state_t hold_d;
    byte_t       held_q;
    byte_t       held_d;
    run_t        run_q;
    run_t        run_d;

    // Word lanes as arrays so both words go through one loop
    word_kind_t  kind_in  [NUM_WORDS];
    byte_t       byte_in  [NUM_WORDS];
    logic        carry_in [NUM_WORDS];

    // Emitted groups in slot order
    logic        grp_emit  [NUM_GROUPS];
    byte_t       grp_held  [NUM_GROUPS];
    logic        grp_carry [NUM_GROUPS];
    run_t        grp_run   [NUM_GROUPS];
    logic [SLOT_W-1:0] slot;

    assign kind_in  = '{kind_1, kind_2};
    assign byte_in  = '{byte_1, byte_2};
    assign carry_in = '{carry_1, carry_2};

    // --------------------------------------------------
    // Sequential resolve of start, word 1, word 2, flush
    // --------------------------------------------------

    always_comb begin
        hold_d = hold_q;
        held_d = held_q;
        run_d  = run_q;
        slot   = '0;
        for (int k = 0; k < NUM_GROUPS; k++) begin
            grp_emit[k]  = 1'b0;
            grp_held[k]  = '0;
            grp_carry[k] = 1'b0;
            grp_run[k]   = '0;
        end

        // A new frame drops whatever the previous one left behind
        if (start) begin
            hold_d = HOLD_EMPTY;
            run_d  = '0;
        end

        for (int w = 0; w < NUM_WORDS; w++) begin
            if ((kind_in[w] == WORD_EXTEND) && (hold_d == HOLD_BYTE)) begin
                // The carry may still ripple through this 0xFF so it stays pending
                run_d = run_d + run_t'(1);
            end else if (kind_in[w] != WORD_NONE) begin
                if (hold_d == HOLD_BYTE) begin
                    grp_emit[slot]  = 1'b1;
                    grp_held[slot]  = held_d;
                    grp_carry[slot] = carry_in[w];
                    grp_run[slot]   = run_d;
                    slot            = slot + SLOT_W'(1);
                end
                hold_d = HOLD_BYTE;
                held_d = byte_in[w];
                run_d  = '0;
            end
        end

        // Flush releases the pending byte as is because no carry can follow any more
        if (flush) begin
            if (hold_d == HOLD_BYTE) begin
                grp_emit[slot]  = 1'b1;
                grp_held[slot]  = held_d;
                grp_carry[slot] = 1'b0;
                grp_run[slot]   = run_d;
            end
            hold_d = HOLD_EMPTY;
            run_d  = '0;
        end
    end

    // --------------------------------------------------
    // State registers
    // --------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_q <= HOLD_EMPTY;
            held_q <= '0;
            run_q  <= '0;
        end else begin
            hold_q <= hold_d;
            held_q <= held_d;
            run_q  <= run_d;
        end
    end

    // --------------------------------------------------
    // Slot outputs
    // --------------------------------------------------

    assign emit_0    = grp_emit[0];
    assign emit_1    = grp_emit[1];
    assign emit_2    = grp_emit[2];
    assign held_0    = grp_held[0];
    assign held_1    = grp_held[1];
    assign held_2    = grp_held[2];
    assign carry_0   = grp_carry[0];
    assign carry_1_o = grp_carry[1];
    assign carry_2_o = grp_carry[2];
    assign run_0     = grp_run[0];
    assign run_1     = grp_run[1];
    assign run_2     = grp_run[2];

    assign flush_done = flush;

endmodule

/* rtl/carry_word_decode.sv */
// Carry word decode: splits each coder word into byte and carry and classifies it
module carry_word_decode (
    input  coder_types_pkg::word_count_t word_count,
    input  coder_types_pkg::word_t       word_1,
    input  coder_types_pkg::word_t       word_2,
    output carry_ctrl_pkg::word_kind_t   kind_1,
    output carry_ctrl_pkg::word_kind_t   kind_2,
    output coder_types_pkg::byte_t       byte_1,
    output coder_types_pkg::byte_t       byte_2,
    output logic                         carry_1,
    output logic                         carry_2
);
    import coder_types_pkg::*;
    import carry_ctrl_pkg::*;

    logic valid_1;
    logic valid_2;

    // Same classification for both lanes
    function automatic word_kind_t classify(input logic valid, input word_t word);
        word_kind_t kind;
        if (!valid) begin
            kind = WORD_NONE;
        end else if ((word[BYTE_W-1:0] == FF_BYTE) && !word[WORD_W-1]) begin
            kind = WORD_EXTEND;
        end else begin
            kind = WORD_RESOLVE;
        end
        return kind;
    endfunction

    // --------------------------------------------------
    // Lane validity
    // --------------------------------------------------

    // Any non-zero count enables word 1
    assign valid_1 = (word_count != '0);

    // Counts 2 and 3 both enable word 2
    assign valid_2 = word_count[1];

    // --------------------------------------------------
    // Split and classify
    // --------------------------------------------------

    assign byte_1  = word_1[BYTE_W-1:0];
    assign byte_2  = word_2[BYTE_W-1:0];
    assign carry_1 = word_1[WORD_W-1];
    assign carry_2 = word_2[WORD_W-1];

    assign kind_1 = classify(valid_1, word_1);
    assign kind_2 = classify(valid_2, word_2);

endmodule

/* rtl/carry_ctrl_pkg.sv */
// Carry resolver control encodings: word classes, hold states and group slot count
package carry_ctrl_pkg;

    // --------------------------------------------------
    // Word classification
    // --------------------------------------------------

    // WORD_EXTEND is 0xFF with a clear carry, which only grows the run
    // while a byte is held. Every other valid word is WORD_RESOLVE
    typedef enum logic [1:0] {
        WORD_NONE    = 2'd0,
        WORD_EXTEND  = 2'd1,
        WORD_RESOLVE = 2'd2
    } word_kind_t;

    // --------------------------------------------------
    // Hold state
    // --------------------------------------------------

    // Whether a byte is waiting for a possible carry from a later word
    typedef enum logic {
        HOLD_EMPTY = 1'b0,
        HOLD_BYTE  = 1'b1
    } hold_state_t;

    // Two resolving words plus one flush can release at most three groups
    localparam int NUM_GROUPS = 3;

endpackage

/* rtl/coder_types_pkg.sv */
// Coder word types: byte, word and run widths shared by the carry resolver datapath
package coder_types_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------

    // One resolved output byte
    localparam int BYTE_W = 8;

    // One coder word is a byte with its carry bit sitting right above it
    localparam int WORD_W = BYTE_W + 1;

    // Up to two words enter per cycle, so two bits are enough for the count
    localparam int WORD_COUNT_W = 2;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    // A byte that is held, resolved or released as a fill value
    typedef logic [BYTE_W-1:0] byte_t;

    // A raw coder word, carry in the MSB
    typedef logic [WORD_W-1:0] word_t;

    // Number of valid words this cycle; 3 is treated like 2
    typedef logic [WORD_COUNT_W-1:0] word_count_t;

    // An all-ones byte without carry only extends the pending run
    localparam byte_t FF_BYTE = '1;

endpackage
